// ==== vlog.f ====
source/cpuControlPkg.sv
source/opcodeDecoder.sv
source/stepCounter.sv
source/phaseSequencer.sv
source/strobeEncoder.sv
source/cpuControl.sv
sim/cpuControlChecker.sv
sim/tbCpuControl.sv

// ==== sim/cpuControl_stimulus.txt ====
// Columns (hex): stop irData run clear ctrl, one line per clock cycle
// ctrl 23..5 = read write baOut rIn rOut gra grb grc marIn mdrIn yIn zIn pcIn irIn incPc zLowOut mdrOut cOut pcOut, 4..0 = aluOp
// reset phase, then one halted cycle
0 D0000000 1 1 000000
0 D0000000 0 0 000000
// add
0 18918000 1 0 009220
0 18918000 1 0 804900
0 18918000 1 0 000480
0 18918000 1 0 0A2000
0 18918000 1 0 091001
0 18918000 1 0 140100
// sub
0 20918000 1 0 009220
0 20918000 1 0 804900
0 20918000 1 0 000480
0 20918000 1 0 0A2000
0 20918000 1 0 091002
0 20918000 1 0 140100
// addi
0 61000005 1 0 009220
0 61000005 1 0 804900
0 61000005 1 0 000480
0 61000005 1 0 0A2000
0 61000005 1 0 001041
0 61000005 1 0 140100
// ori
0 710000F0 1 0 009220
0 710000F0 1 0 804900
0 710000F0 1 0 000480
0 710000F0 1 0 0A2000
0 710000F0 1 0 00104B
0 710000F0 1 0 140100
// ldi
0 09000042 1 0 009220
0 09000042 1 0 804900
0 09000042 1 0 000480
0 09000042 1 0 222000
0 09000042 1 0 001041
0 09000042 1 0 140100
// ld
0 01800010 1 0 009220
0 01800010 1 0 804900
0 01800010 1 0 000480
0 01800010 1 0 222000
0 01800010 1 0 001041
0 01800010 1 0 008100
0 01800010 1 0 804000
0 01800010 1 0 140080
// st, last step idle
0 11800010 1 0 009220
0 11800010 1 0 804900
0 11800010 1 0 000480
0 11800010 1 0 222000
0 11800010 1 0 001041
0 11800010 1 0 008100
0 11800010 1 0 4C4000
0 11800010 1 0 000000
// ld with stop raised in execute step 2, resumes at step 2
0 01800010 1 0 009220
0 01800010 1 0 804900
0 01800010 1 0 000480
0 01800010 1 0 222000
0 01800010 1 0 001041
1 01800010 1 0 008100
1 01800010 0 0 000000
0 01800010 0 0 000000
0 01800010 1 0 008100
0 01800010 1 0 804000
0 01800010 1 0 140080
// nop goes straight back to fetch
0 D0000000 1 0 009220
0 D0000000 1 0 804900
0 D0000000 1 0 000480
// halt, held until a stop pulse
0 D8000000 1 0 009220
0 D8000000 1 0 804900
0 D8000000 1 0 000480
0 D8000000 0 0 000000
0 D8000000 0 0 000000
1 D8000000 0 0 000000
0 D8000000 0 0 000000
// shl after the restart
0 48918000 1 0 009220
0 48918000 1 0 804900
0 48918000 1 0 000480
0 48918000 1 0 0A2000
0 48918000 1 0 091006
0 48918000 1 0 140100

// ==== sim/tbCpuControl.sv ====
// Testbench for the CPU control unit
// Replays a per-cycle stimulus file against the DUT and prints the run summary
module tbCpuControl;

    localparam int ClockPeriod = 20;
    localparam int ResetCycles = 16;
    localparam int MaxFileLines = 200;
    localparam int DrainCycles = 10;

    logic                        clk = 1'b0;
    logic                        reset;
    logic                        stop;
    logic [31:0]                 irData;
    logic                        run;
    logic                        clear;
    cpuControlPkg::controlWord_t ctrl;

    logic                        checkEn;
    logic                        expRun;
    logic                        expClear;
    cpuControlPkg::controlWord_t expCtrl;
    int                          checkErrors;
    int                          checkCount;

    int                          otherErrors;
    int                          lineCount;
    int                          fileLines;
    int                          drainCount;
    int                          fd;
    int                          fields;
    logic [8*160-1:0]            lineText;
    logic [31:0]                 stopField;
    logic [31:0]                 irField;
    logic [31:0]                 runField;
    logic [31:0]                 clearField;
    logic [31:0]                 ctrlField;

    always #(ClockPeriod / 2) clk = ~clk;

    cpuControl #(
        .InstrWidth(32)
    ) dut (
        .clk   (clk),
        .reset (reset),
        .stop  (stop),
        .irData(irData),
        .run   (run),
        .clear (clear),
        .ctrl  (ctrl)
    );

    cpuControlChecker #(
        .SampleDelay(ClockPeriod / 2 - 1)
    ) outputChecker (
        .clk       (clk),
        .checkEn   (checkEn),
        .run       (run),
        .clear     (clear),
        .ctrl      (ctrl),
        .expRun    (expRun),
        .expClear  (expClear),
        .expCtrl   (expCtrl),
        .errorCount(checkErrors),
        .checkCount(checkCount)
    );

    initial begin
        reset = 1'b1;
        stop = 1'b0;
        irData = '0;
        checkEn = 1'b0;
        expRun = 1'b0;
        expClear = 1'b0;
        expCtrl = '0;
        otherErrors = 0;
        lineCount = 0;
        fileLines = 0;

        fd = $fopen("sim/cpuControl_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            otherErrors++;
        end

        repeat (ResetCycles) @(posedge clk);

        while (fd != 0 && !$feof(fd) && fileLines < MaxFileLines) begin
            lineText = '0;
            fileLines++;
            fields = 0;
            if ($fgets(lineText, fd) != 0) begin
                fields = $sscanf(lineText, "%h %h %h %h %h",
                                 stopField, irField, runField, clearField, ctrlField);
            end
            // Comment and blank lines carry no cycle
            if (fields == 5) begin
                @(negedge clk);
                // Reset drops together with the first line
                reset = 1'b0;
                stop = stopField[0];
                irData = irField;
                expRun = runField[0];
                expClear = clearField[0];
                expCtrl = cpuControlPkg::controlWord_t'(ctrlField[23:0]);
                checkEn = 1'b1;
                lineCount++;
            end
        end
        if (fd != 0 && !$feof(fd)) begin
            $display("Stimulus file still not finished after %0d lines", MaxFileLines);
            otherErrors++;
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        @(negedge clk);
        checkEn = 1'b0;
        stop = 1'b0;

        drainCount = 0;
        while (checkCount < lineCount && drainCount < DrainCycles) begin
            @(negedge clk);
            drainCount++;
        end
        if (checkCount < lineCount) begin
            $display("Timed out waiting for the checker, %0d of %0d cycles checked",
                     checkCount, lineCount);
            otherErrors++;
        end
        if (lineCount == 0) begin
            $display("No stimulus cycles were applied");
            otherErrors++;
        end

        $display("Summary: %0d cycles checked, %0d check errors, %0d other errors",
                 checkCount, checkErrors, otherErrors);
        if (checkErrors == 0 && otherErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/cpuControlChecker.sv ====
// Output checker for the CPU control unit
// Compares run, clear and the control word with the expected values each cycle
module cpuControlChecker #(
    parameter int SampleDelay = 9
) (
    input  logic                        clk,
    input  logic                        checkEn,
    input  logic                        run,
    input  logic                        clear,
    input  cpuControlPkg::controlWord_t ctrl,
    input  logic                        expRun,
    input  logic                        expClear,
    input  cpuControlPkg::controlWord_t expCtrl,
    output int                          errorCount,
    output int                          checkCount
);

    task automatic reportMismatch(
        input string       name,
        input logic [23:0] expected,
        input logic [23:0] actual
    );
        $display("CHECK FAILED at time %0t: %s expected %h, got %h",
                 $time, name, expected, actual);
        errorCount++;
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    // Inputs change on the falling edge, so look just before the rising one
    always @(negedge clk) begin
        #(SampleDelay);
        if (checkEn) begin
            if (run !== expRun) begin
                reportMismatch("run", 24'(expRun), 24'(run));
            end
            if (clear !== expClear) begin
                reportMismatch("clear", 24'(expClear), 24'(clear));
            end
            if (ctrl !== expCtrl) begin
                reportMismatch("ctrl", expCtrl, ctrl);
            end
            checkCount++;
        end
    end

endmodule

// ==== source/cpuControl.sv ====
// CPU control unit
// Steps the bus datapath through fetch and execute sequences
module cpuControl #(
    parameter int InstrWidth = 32
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        stop,
    input  logic [InstrWidth-1:0]       irData,
    output logic                        run,
    output logic                        clear,
    output cpuControlPkg::controlWord_t ctrl
);

    cpuControlPkg::instrClass_t instrClass;
    cpuControlPkg::aluOp_t      aluOp;
    cpuControlPkg::phase_t      phase;
    cpuControlPkg::step_t       step;
    logic                       advance;
    logic                       lastStep;

    opcodeDecoder #(
        .InstrWidth(InstrWidth)
    ) decoder (
        .irData    (irData),
        .instrClass(instrClass),
        .aluOp     (aluOp)
    );

    stepCounter counter (
        .clk       (clk),
        .reset     (reset),
        .phase     (phase),
        .instrClass(instrClass),
        .advance   (advance),
        .step      (step),
        .lastStep  (lastStep)
    );

    phaseSequencer sequencer (
        .clk       (clk),
        .reset     (reset),
        .stop      (stop),
        .instrClass(instrClass),
        .lastStep  (lastStep),
        .phase     (phase),
        .advance   (advance),
        .run       (run),
        .clear     (clear)
    );

    strobeEncoder encoder (
        .phase     (phase),
        .step      (step),
        .instrClass(instrClass),
        .aluOp     (aluOp),
        .ctrl      (ctrl)
    );

endmodule

// ==== source/strobeEncoder.sv ====
// Strobe encoder
// Datapath control word for each fetch and execute step
module strobeEncoder (
    input  cpuControlPkg::phase_t        phase,
    input  cpuControlPkg::step_t         step,
    input  cpuControlPkg::instrClass_t   instrClass,
    input  cpuControlPkg::aluOp_t        aluOp,
    output cpuControlPkg::controlWord_t  ctrl
);

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = cpuControlPkg::aluNop;
        case (phase)
            cpuControlPkg::fetchPhase: begin
                case (step)
                    3'd0: begin
                        ctrl.pcOut = 1'b1;
                        ctrl.marIn = 1'b1;
                        ctrl.zIn   = 1'b1;
                        ctrl.incPc = 1'b1;
                    end
                    3'd1: begin
                        ctrl.zLowOut = 1'b1;
                        ctrl.pcIn    = 1'b1;
                        ctrl.read    = 1'b1;
                        ctrl.mdrIn   = 1'b1;
                    end
                    3'd2: begin
                        ctrl.mdrOut = 1'b1;
                        ctrl.irIn   = 1'b1;
                    end
                    default: ;
                endcase
            end
            cpuControlPkg::execPhase: begin
                case (instrClass)
                    cpuControlPkg::aluReg, cpuControlPkg::aluImm: begin
                        case (step)
                            3'd0: begin
                                ctrl.grb  = 1'b1;
                                ctrl.rOut = 1'b1;
                                ctrl.yIn  = 1'b1;
                            end
                            3'd1: begin
                                ctrl.zIn   = 1'b1;
                                ctrl.aluOp = aluOp;
                                // Second operand from register C or the constant
                                if (instrClass == cpuControlPkg::aluReg) begin
                                    ctrl.grc  = 1'b1;
                                    ctrl.rOut = 1'b1;
                                end else begin
                                    ctrl.cOut = 1'b1;
                                end
                            end
                            3'd2: begin
                                ctrl.zLowOut = 1'b1;
                                ctrl.gra     = 1'b1;
                                ctrl.rIn     = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                    cpuControlPkg::load, cpuControlPkg::loadImm, cpuControlPkg::store: begin
                        case (step)
                            3'd0: begin
                                ctrl.grb   = 1'b1;
                                ctrl.baOut = 1'b1;
                                ctrl.yIn   = 1'b1;
                            end
                            3'd1: begin
                                ctrl.zIn   = 1'b1;
                                ctrl.cOut  = 1'b1;
                                ctrl.aluOp = cpuControlPkg::aluAdd;
                            end
                            3'd2: begin
                                ctrl.zLowOut = 1'b1;
                                if (instrClass == cpuControlPkg::loadImm) begin
                                    ctrl.gra = 1'b1;
                                    ctrl.rIn = 1'b1;
                                end else begin
                                    ctrl.marIn = 1'b1;
                                end
                            end
                            3'd3: begin
                                ctrl.mdrIn = 1'b1;
                                if (instrClass == cpuControlPkg::store) begin
                                    ctrl.write = 1'b1;
                                    ctrl.gra   = 1'b1;
                                    ctrl.rOut  = 1'b1;
                                end else begin
                                    ctrl.read = 1'b1;
                                end
                            end
                            3'd4: begin
                                // Store ends on an idle step
                                if (instrClass == cpuControlPkg::load) begin
                                    ctrl.mdrOut = 1'b1;
                                    ctrl.gra    = 1'b1;
                                    ctrl.rIn    = 1'b1;
                                end
                            end
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        assert final (!(ctrl.read && ctrl.write))
            else $error("read and write strobes both high");
        assert final (!(ctrl.rIn && ctrl.rOut))
            else $error("register file driven and loaded at once");
    end

endmodule

// ==== source/phaseSequencer.sv ====
// Phase sequencer
// FSM over reset, halt, fetch and execute with stop/resume and the halt latch
module phaseSequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stop,
    input  cpuControlPkg::instrClass_t instrClass,
    input  logic                       lastStep,
    output cpuControlPkg::phase_t      phase,
    output logic                       advance,
    output logic                       run,
    output logic                       clear
);

    cpuControlPkg::phase_t savedPhase;
    logic                  haltLatch;

    assign advance = !stop && (phase == cpuControlPkg::fetchPhase ||
                               phase == cpuControlPkg::execPhase);
    assign run     = (phase != cpuControlPkg::haltPhase);
    assign clear   = (phase == cpuControlPkg::resetPhase);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase      <= cpuControlPkg::resetPhase;
            savedPhase <= cpuControlPkg::fetchPhase;
            haltLatch  <= 1'b0;
        end else if (stop) begin
            // Freeze and remember where we were
            haltLatch <= 1'b0;
            if (phase == cpuControlPkg::fetchPhase || phase == cpuControlPkg::execPhase) begin
                savedPhase <= phase;
            end
            phase <= cpuControlPkg::haltPhase;
        end else begin
            case (phase)
                cpuControlPkg::resetPhase: begin
                    phase <= cpuControlPkg::haltPhase;
                end
                cpuControlPkg::haltPhase: begin
                    if (!haltLatch) begin
                        phase <= savedPhase;
                    end
                end
                cpuControlPkg::fetchPhase: begin
                    if (lastStep) begin
                        if (instrClass == cpuControlPkg::halt) begin
                            phase      <= cpuControlPkg::haltPhase;
                            savedPhase <= cpuControlPkg::fetchPhase;
                            haltLatch  <= 1'b1;
                        end else if (cpuControlPkg::execLength(instrClass) != 0) begin
                            phase <= cpuControlPkg::execPhase;
                        end
                        // nop simply fetches again
                    end
                end
                default: begin
                    if (lastStep) begin
                        phase <= cpuControlPkg::fetchPhase;
                    end
                end
            endcase
        end
    end

    stopHaltsRun: assert property (
        @(posedge clk) disable iff (reset)
        stop |=> (phase == cpuControlPkg::haltPhase) && !run
    ) else $error("controller still running after stop");

    clearOnlyAfterReset: assert property (
        @(posedge clk) disable iff (reset)
        clear |=> !clear && (phase == cpuControlPkg::haltPhase)
    ) else $error("clear held past the reset phase");

endmodule

// ==== source/stepCounter.sv ====
// Step counter
// Tracks the step inside the current phase and flags the last one
module stepCounter (
    input  logic                       clk,
    input  logic                       reset,
    input  cpuControlPkg::phase_t      phase,
    input  cpuControlPkg::instrClass_t instrClass,
    input  logic                       advance,
    output cpuControlPkg::step_t       step,
    output logic                       lastStep
);

    always_comb begin
        case (phase)
            cpuControlPkg::fetchPhase:
                lastStep = (step == cpuControlPkg::FetchSteps - 1);
            cpuControlPkg::execPhase:
                lastStep = (step == cpuControlPkg::execLength(instrClass) - 1);
            default:
                lastStep = 1'b0;
        endcase
    end

    // Held while advance is low so a stopped sequence picks up where it left off
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step <= '0;
        end else if (advance) begin
            step <= lastStep ? '0 : step + 1'b1;
        end
    end

    execStepInRange: assert property (
        @(posedge clk) disable iff (reset)
        (phase == cpuControlPkg::execPhase) |->
            (step < cpuControlPkg::execLength(instrClass))
    ) else $error("execute step %0d beyond instruction length", step);

endmodule

// ==== source/opcodeDecoder.sv ====
// Opcode decoder
// Turns the opcode field of the instruction into a class and an ALU operation
module opcodeDecoder #(
    parameter int InstrWidth = 32
) (
    input  logic [InstrWidth-1:0]      irData,
    output cpuControlPkg::instrClass_t instrClass,
    output cpuControlPkg::aluOp_t      aluOp
);

    logic [4:0] opcode;

    assign opcode = irData[InstrWidth-1 -: 5];

    always_comb begin
        instrClass = cpuControlPkg::nop;
        aluOp      = cpuControlPkg::aluNop;
        case (opcode)
            cpuControlPkg::opAdd: begin
                instrClass = cpuControlPkg::aluReg;
                aluOp      = cpuControlPkg::aluAdd;
            end
            cpuControlPkg::opSub: begin
                instrClass = cpuControlPkg::aluReg;
                aluOp      = cpuControlPkg::aluSub;
            end
            cpuControlPkg::opAnd: begin
                instrClass = cpuControlPkg::aluReg;
                aluOp      = cpuControlPkg::aluAnd;
            end
            cpuControlPkg::opOr: begin
                instrClass = cpuControlPkg::aluReg;
                aluOp      = cpuControlPkg::aluOr;
            end
            cpuControlPkg::opShl: begin
                instrClass = cpuControlPkg::aluReg;
                aluOp      = cpuControlPkg::aluShl;
            end
            cpuControlPkg::opShr: begin
                instrClass = cpuControlPkg::aluReg;
                aluOp      = cpuControlPkg::aluShr;
            end
            cpuControlPkg::opAddi: begin
                instrClass = cpuControlPkg::aluImm;
                aluOp      = cpuControlPkg::aluAdd;
            end
            cpuControlPkg::opAndi: begin
                instrClass = cpuControlPkg::aluImm;
                aluOp      = cpuControlPkg::aluAnd;
            end
            cpuControlPkg::opOri: begin
                instrClass = cpuControlPkg::aluImm;
                aluOp      = cpuControlPkg::aluOr;
            end
            // Address is base plus constant
            cpuControlPkg::opLd: begin
                instrClass = cpuControlPkg::load;
                aluOp      = cpuControlPkg::aluAdd;
            end
            cpuControlPkg::opLdi: begin
                instrClass = cpuControlPkg::loadImm;
                aluOp      = cpuControlPkg::aluAdd;
            end
            cpuControlPkg::opSt: begin
                instrClass = cpuControlPkg::store;
                aluOp      = cpuControlPkg::aluAdd;
            end
            cpuControlPkg::opHalt: instrClass = cpuControlPkg::halt;
            // Unsupported opcodes fall through as nop
            default:               instrClass = cpuControlPkg::nop;
        endcase
    end

endmodule

// ==== source/cpuControlPkg.sv ====
// CPU control package
// Opcodes, ALU codes, phases and the datapath control word
package cpuControlPkg;

    // Instruction opcodes kept from the full instruction set
    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opLdi  = 5'b00001,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opShr  = 5'b00111,
        opShl  = 5'b01001,
        opAddi = 5'b01100,
        opAndi = 5'b01101,
        opOri  = 5'b01110,
        opNop  = 5'b11010,
        opHalt = 5'b11011
    } opcode_t;

    typedef enum logic [4:0] {
        aluNop = 5'd0,
        aluAdd = 5'd1,
        aluSub = 5'd2,
        aluShr = 5'd5,
        aluShl = 5'd6,
        aluAnd = 5'd10,
        aluOr  = 5'd11
    } aluOp_t;

    typedef enum logic [2:0] {
        aluReg,
        aluImm,
        load,
        loadImm,
        store,
        nop,
        halt
    } instrClass_t;

    typedef enum logic [1:0] {
        resetPhase,
        haltPhase,
        fetchPhase,
        execPhase
    } phase_t;

    typedef logic [2:0] step_t;

    typedef struct packed {
        logic   read;
        logic   write;
        logic   baOut;
        logic   rIn;
        logic   rOut;
        logic   gra;
        logic   grb;
        logic   grc;
        logic   marIn;
        logic   mdrIn;
        logic   yIn;
        logic   zIn;
        logic   pcIn;
        logic   irIn;
        logic   incPc;
        logic   zLowOut;
        logic   mdrOut;
        logic   cOut;
        logic   pcOut;
        aluOp_t aluOp;
    } controlWord_t;

    localparam int FetchSteps = 3;

    // Execute steps per instruction class
    function automatic int execLength(instrClass_t instrClass);
        case (instrClass)
            aluReg, aluImm, loadImm: return 3;
            load, store:             return 5;
            default:                 return 0;
        endcase
    endfunction

endpackage
